/* verilog/bus_pkg.sv */
/*
 * CPU bus definitions
 * Address map of the memory-mapped bus plus the data, strobe and
 * board port widths shared by the decoder and the RAM.
 */
package bus_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   typedef logic [3:0]  strb_t;

   // byte address inside the 32 KiB RAM window
   typedef logic [14:0] ram_addr_t;

   localparam int RAM_WORDS = 8192;

   // peripheral registers
   localparam addr_t ADDR_DIP          = 32'h8000_0000;
   localparam addr_t ADDR_LED          = 32'h8000_0004;
   localparam addr_t ADDR_BUTTONS      = 32'h8000_0008;
   localparam addr_t ADDR_AUDIO_STATUS = 32'h8000_000C;
   localparam addr_t ADDR_AUDIO_L      = 32'h8000_0010;
   localparam addr_t ADDR_AUDIO_R      = 32'h8000_0014;

   // board i/o
   typedef logic [7:0] led_t;
   typedef logic [4:0] buttons_t;
   typedef logic [7:0] dip_t;

endpackage

/* verilog/audio_pkg.sv */
/*
 * Audio path definitions
 * Sample format, FIFO depth, sample-rate divider and the power-up
 * wait that stands in for codec configuration.
 */
package audio_pkg;

   typedef logic signed [23:0] sample_t;

   // pairs held in the sample FIFO
   localparam int FIFO_DEPTH = 16;

   // clock cycles per sample tick
   localparam int SAMPLE_DIV = 32;

   // cycles until codec configuration is reported complete
   localparam int INIT_CYCLES = 600;

endpackage

/* verilog/cpu_bus_logic.sv */
/*
 * CPU bus decoder
 * Routes CPU accesses to the block RAM or the peripheral registers,
 * muxes read data and ready, holds the LED register and the left and
 * right sample registers, and hands sample pairs to the audio FIFO.
 */
`timescale 1ns/1ps

module cpu_bus_logic (
   input  logic                clk,
   input  logic                reset,
   input  bus_pkg::addr_t      addr,
   input  bus_pkg::word_t      wdata,
   input  bus_pkg::strb_t      wstrb,
   input  logic                valid,
   output bus_pkg::word_t      rdata,
   output logic                ready,
   input  bus_pkg::dip_t       dip,
   input  bus_pkg::buttons_t   buttons,
   output bus_pkg::led_t       led,
   output bus_pkg::ram_addr_t  ram_addr,
   output bus_pkg::word_t      ram_wdata,
   output bus_pkg::strb_t      ram_wstrb,
   output logic                ram_valid,
   input  bus_pkg::word_t      ram_rdata,
   input  logic                ram_ready,
   output audio_pkg::sample_t  audio_l,
   output audio_pkg::sample_t  audio_r,
   output logic                audio_valid,
   input  logic                audio_full,
   input  logic                init_done
);

   logic ram_hit;

   // RAM occupies the low 32 KiB, everything above bit 14 must be zero
   assign ram_hit = (addr[$bits(bus_pkg::addr_t)-1:$bits(bus_pkg::ram_addr_t)] == '0);

   assign ram_addr  = addr[$bits(bus_pkg::ram_addr_t)-1:0];
   assign ram_wdata = wdata;
   assign ram_wstrb = wstrb;

   // read mux and ready select
   always_comb begin
      ram_valid = 1'b0;
      ready     = 1'b1;
      rdata     = '0;
      if (ram_hit) begin
         rdata     = ram_rdata;
         ram_valid = valid;
         ready     = ram_ready;
      end else begin
         case (addr)
            bus_pkg::ADDR_DIP:          rdata = bus_pkg::word_t'(dip);
            bus_pkg::ADDR_LED:          rdata = bus_pkg::word_t'(led);
            bus_pkg::ADDR_BUTTONS:      rdata = bus_pkg::word_t'(buttons);
            bus_pkg::ADDR_AUDIO_STATUS: rdata = {30'b0, init_done, audio_full};
            default:                    rdata = '0;
         endcase
      end
   end

   // peripheral writes complete in the cycle valid is seen
   always_ff @(posedge clk) begin
      if (reset) begin
         led         <= '0;
         audio_l     <= '0;
         audio_r     <= '0;
         audio_valid <= 1'b0;
      end else begin
         // pair is taken by the FIFO once it has room
         if (audio_valid && !audio_full)
            audio_valid <= 1'b0;

         if (valid) begin
            case (addr)
               bus_pkg::ADDR_LED: begin
                  if (wstrb[0])
                     led <= wdata[7:0];
               end
               bus_pkg::ADDR_AUDIO_L: begin
                  for (int i = 0; i < 3; i++)
                     if (wstrb[i])
                        audio_l[8*i +: 8] <= wdata[8*i +: 8];
               end
               bus_pkg::ADDR_AUDIO_R: begin
                  for (int i = 0; i < 3; i++)
                     if (wstrb[i])
                        audio_r[8*i +: 8] <= wdata[8*i +: 8];
                  if (|wstrb)
                     audio_valid <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

endmodule

/* verilog/bus_ram.sv */
/*
 * Bus block RAM
 * 32 KiB of word-organized memory with per-byte write enables.
 * Each request is answered with a single-cycle ready one clock
 * after valid, together with the registered read data.
 */
`timescale 1ns/1ps

module bus_ram (
   input  logic                clk,
   input  bus_pkg::ram_addr_t  ram_addr,
   input  bus_pkg::word_t      ram_wdata,
   input  bus_pkg::strb_t      ram_wstrb,
   input  logic                ram_valid,
   output bus_pkg::word_t      ram_rdata,
   output logic                ram_ready,
   input  logic                reset
);

   bus_pkg::word_t mem [bus_pkg::RAM_WORDS];

   logic [$clog2(bus_pkg::RAM_WORDS)-1:0] word_idx;
   logic                                  access;

   assign word_idx = ram_addr[$clog2(bus_pkg::RAM_WORDS)+1:2];

   // first cycle of a request, the ready cycle itself is skipped
   assign access = ram_valid && !ram_ready;

   always_ff @(posedge clk) begin
      if (access) begin
         ram_rdata <= mem[word_idx];
         for (int i = 0; i < $bits(bus_pkg::strb_t); i++)
            if (ram_wstrb[i])
               mem[word_idx][8*i +: 8] <= ram_wdata[8*i +: 8];
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         ram_ready <= 1'b0;
      else
         ram_ready <= access;
   end

endmodule

/* verilog/audio_fifo.sv */
/*
 * Audio sample FIFO
 * Circular buffer of left/right sample pairs with an occupancy
 * count. The head pair is visible without a pop.
 */
`timescale 1ns/1ps

module audio_fifo (
   input  logic                clk,
   input  logic                reset,
   input  logic                push,
   input  audio_pkg::sample_t  push_l,
   input  audio_pkg::sample_t  push_r,
   input  logic                pop,
   output audio_pkg::sample_t  head_l,
   output audio_pkg::sample_t  head_r,
   output logic                full,
   output logic                empty
);

   audio_pkg::sample_t mem_l [audio_pkg::FIFO_DEPTH];
   audio_pkg::sample_t mem_r [audio_pkg::FIFO_DEPTH];

   logic [$clog2(audio_pkg::FIFO_DEPTH)-1:0] wr_ptr;
   logic [$clog2(audio_pkg::FIFO_DEPTH)-1:0] rd_ptr;
   logic [$clog2(audio_pkg::FIFO_DEPTH):0]   count;
   logic                                     do_push;
   logic                                     do_pop;

   assign full    = (count == audio_pkg::FIFO_DEPTH);
   assign empty   = (count == '0);
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   assign head_l = mem_l[rd_ptr];
   assign head_r = mem_r[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem_l[wr_ptr] <= push_l;
         mem_r[wr_ptr] <= push_r;
      end
   end

   // pointers wrap at the power-of-two depth
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

endmodule

/* verilog/audio_playback.sv */
/*
 * Audio playback
 * Waits out the codec power-up time, then drains one sample pair
 * from the FIFO per sample tick and presents it with a strobe.
 */
`timescale 1ns/1ps

module audio_playback (
   input  logic                clk,
   input  logic                reset,
   input  logic                empty,
   input  audio_pkg::sample_t  head_l,
   input  audio_pkg::sample_t  head_r,
   output logic                pop,
   output logic                init_done,
   output audio_pkg::sample_t  sample_l,
   output audio_pkg::sample_t  sample_r,
   output logic                sample_strobe
);

   logic [$clog2(audio_pkg::INIT_CYCLES)-1:0] init_cnt;
   logic [$clog2(audio_pkg::SAMPLE_DIV)-1:0]  div_cnt;
   logic                                      tick;

   assign tick = init_done && (div_cnt == audio_pkg::SAMPLE_DIV - 1);
   assign pop  = tick && !empty;

   // power-up wait, stands in for codec configuration
   always_ff @(posedge clk) begin
      if (reset) begin
         init_cnt  <= '0;
         init_done <= 1'b0;
      end else if (!init_done) begin
         if (init_cnt == audio_pkg::INIT_CYCLES - 1)
            init_done <= 1'b1;
         else
            init_cnt <= init_cnt + 1'b1;
      end
   end

   // free-running sample-rate divider
   always_ff @(posedge clk) begin
      if (reset)
         div_cnt <= '0;
      else if (init_done)
         div_cnt <= tick ? '0 : div_cnt + 1'b1;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         sample_l      <= '0;
         sample_r      <= '0;
         sample_strobe <= 1'b0;
      end else begin
         sample_strobe <= pop;
         if (pop) begin
            sample_l <= head_l;
            sample_r <= head_r;
         end
      end
   end

endmodule

/* verilog/soc_bus_top.sv */
/*
 * SoC bus top level
 * CPU memory port into the decoder, with the block RAM and the
 * audio FIFO and playback path alongside.
 */
`timescale 1ns/1ps

module soc_bus_top (
   input  logic                clk,
   input  logic                reset,
   input  bus_pkg::addr_t      addr,
   input  bus_pkg::word_t      wdata,
   input  bus_pkg::strb_t      wstrb,
   input  logic                valid,
   output bus_pkg::word_t      rdata,
   output logic                ready,
   input  bus_pkg::dip_t       dip,
   input  bus_pkg::buttons_t   buttons,
   output bus_pkg::led_t       led,
   output audio_pkg::sample_t  sample_l,
   output audio_pkg::sample_t  sample_r,
   output logic                sample_strobe
);

   bus_pkg::ram_addr_t  ram_addr;
   bus_pkg::word_t      ram_wdata;
   bus_pkg::strb_t      ram_wstrb;
   logic                ram_valid;
   bus_pkg::word_t      ram_rdata;
   logic                ram_ready;

   audio_pkg::sample_t  audio_l;
   audio_pkg::sample_t  audio_r;
   logic                audio_valid;
   logic                audio_full;
   logic                init_done;

   audio_pkg::sample_t  head_l;
   audio_pkg::sample_t  head_r;
   logic                fifo_empty;
   logic                pop;

   cpu_bus_logic u_cpu_bus_logic (
      .clk         (clk),
      .reset       (reset),
      .addr        (addr),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .valid       (valid),
      .rdata       (rdata),
      .ready       (ready),
      .dip         (dip),
      .buttons     (buttons),
      .led         (led),
      .ram_addr    (ram_addr),
      .ram_wdata   (ram_wdata),
      .ram_wstrb   (ram_wstrb),
      .ram_valid   (ram_valid),
      .ram_rdata   (ram_rdata),
      .ram_ready   (ram_ready),
      .audio_l     (audio_l),
      .audio_r     (audio_r),
      .audio_valid (audio_valid),
      .audio_full  (audio_full),
      .init_done   (init_done)
   );

   bus_ram u_bus_ram (
      .clk       (clk),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .ram_wstrb (ram_wstrb),
      .ram_valid (ram_valid),
      .ram_rdata (ram_rdata),
      .ram_ready (ram_ready),
      .reset     (reset)
   );

   // pending pair is pushed whenever the FIFO has room
   audio_fifo u_audio_fifo (
      .clk    (clk),
      .reset  (reset),
      .push   (audio_valid),
      .push_l (audio_l),
      .push_r (audio_r),
      .pop    (pop),
      .head_l (head_l),
      .head_r (head_r),
      .full   (audio_full),
      .empty  (fifo_empty)
   );

   audio_playback u_audio_playback (
      .clk           (clk),
      .reset         (reset),
      .empty         (fifo_empty),
      .head_l        (head_l),
      .head_r        (head_r),
      .pop           (pop),
      .init_done     (init_done),
      .sample_l      (sample_l),
      .sample_r      (sample_r),
      .sample_strobe (sample_strobe)
   );

endmodule

/* tests/soc_bus_checker.sv */
/*
 * Bus and audio path checker
 * Concurrent assertions bound into the SoC top level: RAM select
 * range, sample pair handling at a full FIFO, playback start and
 * LED register updates.
 */
`timescale 1ns/1ps

module soc_bus_checker (
   input logic               clk,
   input logic               reset,
   input bus_pkg::addr_t     addr,
   input bus_pkg::strb_t     wstrb,
   input logic               valid,
   input bus_pkg::led_t      led,
   input logic               ram_valid,
   input logic               audio_valid,
   input logic               audio_full,
   input logic               init_done,
   input logic               sample_strobe
);

   // RAM only selected inside its 32 KiB window
   assert property (@(posedge clk) disable iff (reset)
      ram_valid |-> (addr[31:15] == '0))
      else $error("ram_valid asserted outside the RAM range");

   // pending pair stays in the registers while the FIFO is full
   assert property (@(posedge clk) disable iff (reset)
      (audio_valid && audio_full) |=> audio_valid)
      else $error("sample pair pushed or dropped while FIFO full");

   assert property (@(posedge clk) disable iff (reset)
      sample_strobe |-> init_done)
      else $error("sample_strobe before codec configuration complete");

   assert property (@(posedge clk) disable iff (reset)
      (led != $past(led)) |-> $past(valid && addr == bus_pkg::ADDR_LED && wstrb[0]))
      else $error("led changed without a write to the LED register");

endmodule

/* tests/soc_bus_tb.sv */
/*
 * SoC bus testbench
 * Drives the CPU memory port through RAM, board I/O and audio
 * accesses, checks read data against a reference model and the
 * played-back sample pairs against the order they were written.
 */
`timescale 1ns/1ps

module soc_bus_tb;

   localparam int ACCESS_LIMIT = 20;
   localparam int RAM_TESTS    = 12;
   localparam int PAIRS        = audio_pkg::FIFO_DEPTH + 1;

   logic               clk;
   logic               reset;
   bus_pkg::addr_t     addr;
   bus_pkg::word_t     wdata;
   bus_pkg::strb_t     wstrb;
   logic               valid;
   bus_pkg::word_t     rdata;
   logic               ready;
   bus_pkg::dip_t      dip;
   bus_pkg::buttons_t  buttons;
   bus_pkg::led_t      led;
   audio_pkg::sample_t sample_l;
   audio_pkg::sample_t sample_r;
   logic               sample_strobe;

   // reference model state
   bus_pkg::word_t     ram_model [int];
   bus_pkg::led_t      led_model;
   audio_pkg::sample_t model_l;
   audio_pkg::sample_t model_r;
   audio_pkg::sample_t exp_l_q [$];
   audio_pkg::sample_t exp_r_q [$];

   logic [31:0]        lfsr;
   int                 cycle = 0;
   int                 rd_cycle;
   int                 pairs_seen = 0;
   bus_pkg::addr_t     test_addrs [RAM_TESTS];

   soc_bus_top u_soc_bus_top (
      .clk           (clk),
      .reset         (reset),
      .addr          (addr),
      .wdata         (wdata),
      .wstrb         (wstrb),
      .valid         (valid),
      .rdata         (rdata),
      .ready         (ready),
      .dip           (dip),
      .buttons       (buttons),
      .led           (led),
      .sample_l      (sample_l),
      .sample_r      (sample_r),
      .sample_strobe (sample_strobe)
   );

   bind soc_bus_top soc_bus_checker u_soc_bus_checker (
      .clk           (clk),
      .reset         (reset),
      .addr          (addr),
      .wstrb         (wstrb),
      .valid         (valid),
      .led           (led),
      .ram_valid     (ram_valid),
      .audio_valid   (audio_valid),
      .audio_full    (audio_full),
      .init_done     (init_done),
      .sample_strobe (sample_strobe)
   );

   always #5 clk = ~clk;

   // clock edges since reset release
   always @(posedge clk)
      if (!reset)
         cycle <= cycle + 1;

   // Galois LFSR stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits = {bits[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return bits;
   endfunction

   function automatic bus_pkg::word_t merge_bytes(input bus_pkg::word_t old_w,
                                                  input bus_pkg::word_t new_w,
                                                  input bus_pkg::strb_t s);
      bus_pkg::word_t res;
      res = old_w;
      for (int i = 0; i < 4; i++)
         if (s[i])
            res[8*i +: 8] = new_w[8*i +: 8];
      return res;
   endfunction

   function automatic bus_pkg::word_t expected_read(input bus_pkg::addr_t a);
      if (a[31:15] == '0)
         return ram_model[int'(a[14:2])];
      case (a)
         bus_pkg::ADDR_DIP:     return 32'(dip);
         bus_pkg::ADDR_LED:     return 32'(led_model);
         bus_pkg::ADDR_BUTTONS: return 32'(buttons);
         default:               return '0;
      endcase
   endfunction

   task automatic model_write(input bus_pkg::addr_t a, input bus_pkg::word_t d,
                              input bus_pkg::strb_t s);
      bus_pkg::word_t w;
      if (a[31:15] == '0) begin
         w = ram_model.exists(int'(a[14:2])) ? ram_model[int'(a[14:2])] : '0;
         ram_model[int'(a[14:2])] = merge_bytes(w, d, s);
      end else if (a == bus_pkg::ADDR_LED) begin
         if (s[0])
            led_model = d[7:0];
      end else if (a == bus_pkg::ADDR_AUDIO_L) begin
         w = merge_bytes({8'h00, model_l}, d, s);
         model_l = w[23:0];
      end else if (a == bus_pkg::ADDR_AUDIO_R) begin
         w = merge_bytes({8'h00, model_r}, d, s);
         model_r = w[23:0];
         // any strobe hands the pair to the FIFO
         if (|s) begin
            exp_l_q.push_back(model_l);
            exp_r_q.push_back(model_r);
         end
      end
   endtask

   task automatic stop_with_error(input string what);
      $display("%s", what);
      $display("Done: errors found");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         stop_with_error($sformatf("Error: %s is %h, expected %h", name, got, exp));
   endtask

   // one access on the CPU port held until ready is seen
   task automatic bus_access(input bus_pkg::addr_t a, input bus_pkg::word_t d,
                             input bus_pkg::strb_t s, output bus_pkg::word_t rd);
      int n;
      @(negedge clk);
      addr  = a;
      wdata = d;
      wstrb = s;
      valid = 1'b1;
      #1;
      n = 0;
      while (!ready) begin
         if (n == ACCESS_LIMIT)
            stop_with_error($sformatf("no ready for the access to address %h", a));
         @(negedge clk);
         n++;
      end
      // RAM answers one cycle late and peripherals at once
      check_equal("ready wait cycles", 32'(n), (a[31:15] == '0) ? 32'h1 : 32'h0);
      rd       = rdata;
      rd_cycle = cycle;
      @(posedge clk);
      @(negedge clk);
      valid = 1'b0;
      wstrb = '0;
   endtask

   task automatic write_word(input bus_pkg::addr_t a, input bus_pkg::word_t d,
                             input bus_pkg::strb_t s);
      bus_pkg::word_t unused;
      bus_access(a, d, s, unused);
      model_write(a, d, s);
   endtask

   task automatic read_check(input bus_pkg::addr_t a);
      bus_pkg::word_t rd;
      bus_access(a, '0, '0, rd);
      check_equal($sformatf("rdata at %h", a), rd, expected_read(a));
   endtask

   // configuration bit follows the power-up wait exactly
   task automatic status_read(output bus_pkg::word_t st);
      bus_access(bus_pkg::ADDR_AUDIO_STATUS, '0, '0, st);
      check_equal("status[1]", 32'(st[1]), 32'(rd_cycle >= audio_pkg::INIT_CYCLES));
   endtask

   task automatic wait_for_pairs(input int target, input int limit);
      int n;
      n = 0;
      while (pairs_seen < target) begin
         if (n == limit)
            stop_with_error($sformatf("only %0d of %0d sample pairs were played",
                                      pairs_seen, target));
         @(negedge clk);
         n++;
      end
   endtask

   // each strobe is matched against the oldest written pair
   always @(negedge clk) begin
      if (!reset && sample_strobe) begin
         if (exp_l_q.size() == 0) begin
            stop_with_error("sample_strobe with no sample pair written");
         end else begin
            check_equal("sample_l", 32'(sample_l), 32'(exp_l_q.pop_front()));
            check_equal("sample_r", 32'(sample_r), 32'(exp_r_q.pop_front()));
            pairs_seen <= pairs_seen + 1;
         end
      end
   end

   initial begin
      bus_pkg::word_t st;
      bus_pkg::word_t d;
      bus_pkg::strb_t s;
      int             polls;
      clk        = 1'b0;
      reset      = 1'b1;
      addr       = '0;
      wdata      = '0;
      wstrb      = '0;
      valid      = 1'b0;
      dip        = '0;
      buttons    = '0;
      lfsr       = 32'h3ab4b12c;
      rd_cycle   = 0;
      led_model  = '0;
      model_l    = '0;
      model_r    = '0;
      repeat (4) @(negedge clk);
      reset = 1'b0;

      status_read(st);

      // full word first and then a byte-strobed overwrite
      for (int i = 0; i < RAM_TESTS; i++) begin
         test_addrs[i] = rand_bits(13) << 2;
         d = rand_bits(32);
         write_word(test_addrs[i], d, 4'hf);
         d = rand_bits(32);
         s = bus_pkg::strb_t'(rand_bits(4));
         write_word(test_addrs[i], d, s);
      end
      for (int i = 0; i < RAM_TESTS; i++)
         read_check(test_addrs[i]);

      // board i/o and unmapped space
      @(negedge clk);
      dip     = bus_pkg::dip_t'(rand_bits(8));
      buttons = bus_pkg::buttons_t'(rand_bits(5));
      d = rand_bits(32);
      write_word(bus_pkg::ADDR_LED, d, 4'h1);
      check_equal("led", 32'(led), 32'(led_model));
      d = rand_bits(32);
      write_word(bus_pkg::ADDR_LED, d, 4'he);
      write_word(32'h8000_0018, d, 4'hf);
      check_equal("led", 32'(led), 32'(led_model));
      read_check(bus_pkg::ADDR_LED);
      read_check(bus_pkg::ADDR_DIP);
      read_check(bus_pkg::ADDR_BUTTONS);
      read_check(32'h8000_0018);
      read_check(32'h8000_0002);
      read_check(32'h4000_0000);

      // fill the FIFO before playback so the last pair waits in the registers
      for (int i = 0; i < PAIRS; i++) begin
         d = rand_bits(32);
         s = bus_pkg::strb_t'(rand_bits(4));
         write_word(bus_pkg::ADDR_AUDIO_L, d, s);
         d = rand_bits(32);
         s = bus_pkg::strb_t'(rand_bits(4)) | 4'h1;
         write_word(bus_pkg::ADDR_AUDIO_R, d, s);
      end
      status_read(st);
      check_equal("status[0]", 32'(st[0]), 32'h1);

      polls = 0;
      while (!st[1]) begin
         if (polls == audio_pkg::INIT_CYCLES)
            stop_with_error("codec configuration was never reported complete");
         status_read(st);
         polls++;
      end

      wait_for_pairs(PAIRS, (PAIRS + 2) * audio_pkg::SAMPLE_DIV);

      // single pairs once playback is running
      for (int i = 0; i < 3; i++) begin
         d = rand_bits(32);
         write_word(bus_pkg::ADDR_AUDIO_L, d, 4'h7);
         d = rand_bits(32);
         write_word(bus_pkg::ADDR_AUDIO_R, d, 4'h7);
         wait_for_pairs(PAIRS + i + 1, 4 * audio_pkg::SAMPLE_DIV);
      end

      // FIFO drained so the full flag is clear again
      status_read(st);
      check_equal("status[0]", 32'(st[0]), 32'h0);

      $display("Done: no errors");
      $finish;
   end

endmodule

/* list.f */
verilog/bus_pkg.sv
verilog/audio_pkg.sv
verilog/cpu_bus_logic.sv
verilog/bus_ram.sv
verilog/audio_fifo.sv
verilog/audio_playback.sv
verilog/soc_bus_top.sv
tests/soc_bus_checker.sv
tests/soc_bus_tb.sv

/* Makefile */
# Verilator build and run of the SoC bus testbench

TOOL       := verilator
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := soc_bus_tb
FILE_LIST  := list.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

# exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)
